//--- cnt_pkg.sv
`default_nettype none

package cnt_pkg;

  // channel count and datapath widths
  localparam int CNT_NUM = 4;
  localparam int CNT_W   = 32;
  // two interrupt sources per channel, compare at 2n and capture at 2n+1
  localparam int INTR_W  = 2 * CNT_NUM;

  // global register byte offsets
  localparam logic [31:0] ADDR_GLB_TRIG = 32'h00;
  localparam logic [31:0] ADDR_INTR_STS = 32'h04;
  localparam logic [31:0] ADDR_MASK_SET = 32'h08;
  localparam logic [31:0] ADDR_MASK_CLR = 32'h0C;

  // bits of the global trigger word
  localparam int TRIG_START_BIT = 0;
  localparam int TRIG_STOP_BIT  = 1;
  localparam int TRIG_CLEAR_BIT = 2;

  // channel window, one 16-byte block per channel
  localparam logic [31:0] CH_BASE   = 32'h20;
  localparam logic [31:0] CH_STRIDE = 32'h10;

  // register offsets inside a channel block
  localparam logic [3:0] OFS_CTRL    = 4'h0;
  localparam logic [3:0] OFS_TARGET  = 4'h4;
  localparam logic [3:0] OFS_COUNT   = 4'h8;
  localparam logic [3:0] OFS_CAPTURE = 4'hC;

  // CTRL bit positions
  localparam int CTRL_EN_BIT    = 0;
  localparam int CTRL_EDGE_BIT  = 1;
  localparam int CTRL_OVWR_BIT  = 2;
  localparam int CTRL_START_BIT = 4;
  localparam int CTRL_STOP_BIT  = 5;
  localparam int CTRL_CLEAR_BIT = 6;
  localparam int CTRL_RUN_BIT   = 8;
  localparam int CTRL_FULL_BIT  = 9;

  // per-channel configuration from the register block
  typedef struct packed {
    logic             enable;
    logic             capture_edge;
    logic             overwrite;
    logic [CNT_W-1:0] target;
  } cnt_cfg_t;

  // single-cycle trigger pulses
  typedef struct packed {
    logic start;
    logic stop;
    logic clear;
  } cnt_trig_t;

  // per-channel status back to the register block
  typedef struct packed {
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] capture;
    logic             running;
    logic             cap_full;
    logic             cmp_evt;
    logic             cap_evt;
  } cnt_stat_t;

  // write strobes into the interrupt controller, one shared data word
  typedef struct packed {
    logic              sts_clr_wr;
    logic              mask_set_wr;
    logic              mask_clr_wr;
    logic [INTR_W-1:0] data;
  } intr_wr_t;

endpackage

`default_nettype wire

//--- cnt_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cnt_apb_regs (
  input  logic                      i_pclk,
  input  logic                      i_prst_n,
  input  logic [31:0]               i_paddr,
  input  logic [31:0]               i_pwdata,
  input  logic                      i_pwrite,
  input  logic                      i_psel,
  input  logic                      i_penable,
  output logic [31:0]               o_prdata,
  output cnt_pkg::cnt_cfg_t         o_cfg [cnt_pkg::CNT_NUM],
  output cnt_pkg::cnt_trig_t        o_trig [cnt_pkg::CNT_NUM],
  output logic [cnt_pkg::CNT_NUM-1:0] o_cap_read,
  input  cnt_pkg::cnt_stat_t        i_stat [cnt_pkg::CNT_NUM],
  output cnt_pkg::intr_wr_t         o_intr_wr,
  input  logic [cnt_pkg::INTR_W-1:0] i_intr_sts,
  input  logic [cnt_pkg::INTR_W-1:0] i_intr_mask
);

  logic               wr_en;
  logic               rd_en;
  logic [31:0]        rdata_mux;
  cnt_pkg::cnt_cfg_t  cfg_q [cnt_pkg::CNT_NUM];
  cnt_pkg::cnt_trig_t trig_q [cnt_pkg::CNT_NUM];

  // true when addr falls in the 16-byte block of channel n
  function automatic logic ch_match(input logic [31:0] addr, input int n);
    logic [31:0] base;
    base = cnt_pkg::CH_BASE + n * cnt_pkg::CH_STRIDE;
    return addr[31:4] == base[31:4];
  endfunction

  // zero-wait APB, everything acts in the setup phase
  assign wr_en = i_psel & i_pwrite & ~i_penable;
  assign rd_en = i_psel & ~i_pwrite & ~i_penable;

  // interrupt strobes go straight through, status and mask update at this edge
  assign o_intr_wr.sts_clr_wr  = wr_en && (i_paddr == cnt_pkg::ADDR_INTR_STS);
  assign o_intr_wr.mask_set_wr = wr_en && (i_paddr == cnt_pkg::ADDR_MASK_SET);
  assign o_intr_wr.mask_clr_wr = wr_en && (i_paddr == cnt_pkg::ADDR_MASK_CLR);
  assign o_intr_wr.data        = i_pwdata[cnt_pkg::INTR_W-1:0];

  // capture read returns the credit at the same edge the data is latched
  always_comb begin
    for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
      o_cap_read[n] = rd_en && ch_match(i_paddr, n) &&
                      (i_paddr[3:0] == cnt_pkg::OFS_CAPTURE);
    end
  end

  // config registers and registered trigger pulses
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
        cfg_q[n]  <= '0;
        trig_q[n] <= '0;
      end
    end else begin
      for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
        // pulses drop after one cycle
        trig_q[n] <= '0;
        if (wr_en && ch_match(i_paddr, n)) begin
          case (i_paddr[3:0])
            cnt_pkg::OFS_CTRL: begin
              cfg_q[n].enable       <= i_pwdata[cnt_pkg::CTRL_EN_BIT];
              cfg_q[n].capture_edge <= i_pwdata[cnt_pkg::CTRL_EDGE_BIT];
              cfg_q[n].overwrite    <= i_pwdata[cnt_pkg::CTRL_OVWR_BIT];
              // single triggers are not gated by enable
              trig_q[n].start <= i_pwdata[cnt_pkg::CTRL_START_BIT];
              trig_q[n].stop  <= i_pwdata[cnt_pkg::CTRL_STOP_BIT];
              trig_q[n].clear <= i_pwdata[cnt_pkg::CTRL_CLEAR_BIT];
            end
            cnt_pkg::OFS_TARGET: cfg_q[n].target <= i_pwdata;
            default: ;
          endcase
        end
        // global trigger only reaches enabled channels
        if (wr_en && (i_paddr == cnt_pkg::ADDR_GLB_TRIG) && cfg_q[n].enable) begin
          trig_q[n].start <= i_pwdata[cnt_pkg::TRIG_START_BIT];
          trig_q[n].stop  <= i_pwdata[cnt_pkg::TRIG_STOP_BIT];
          trig_q[n].clear <= i_pwdata[cnt_pkg::TRIG_CLEAR_BIT];
        end
      end
    end
  end

  assign o_cfg  = cfg_q;
  assign o_trig = trig_q;

  // read-back mux, unmapped and write-only words give 0
  always_comb begin
    rdata_mux = '0;
    case (i_paddr)
      cnt_pkg::ADDR_INTR_STS: rdata_mux[cnt_pkg::INTR_W-1:0] = i_intr_sts;
      cnt_pkg::ADDR_MASK_SET: rdata_mux[cnt_pkg::INTR_W-1:0] = i_intr_mask;
      default: ;
    endcase
    for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
      if (ch_match(i_paddr, n)) begin
        case (i_paddr[3:0])
          cnt_pkg::OFS_CTRL: begin
            // trigger bits read back as 0
            rdata_mux[cnt_pkg::CTRL_EN_BIT]   = cfg_q[n].enable;
            rdata_mux[cnt_pkg::CTRL_EDGE_BIT] = cfg_q[n].capture_edge;
            rdata_mux[cnt_pkg::CTRL_OVWR_BIT] = cfg_q[n].overwrite;
            rdata_mux[cnt_pkg::CTRL_RUN_BIT]  = i_stat[n].running;
            rdata_mux[cnt_pkg::CTRL_FULL_BIT] = i_stat[n].cap_full;
          end
          cnt_pkg::OFS_TARGET:  rdata_mux = cfg_q[n].target;
          cnt_pkg::OFS_COUNT:   rdata_mux = i_stat[n].count;
          cnt_pkg::OFS_CAPTURE: rdata_mux = i_stat[n].capture;
          default: ;
        endcase
      end
    end
  end

  // read data latched at the end of setup, held until the next read
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_prdata <= '0;
    end else if (rd_en) begin
      o_prdata <= rdata_mux;
    end
  end

  // no trigger may stay high for two cycles
  for (genvar n = 0; n < cnt_pkg::CNT_NUM; n++) begin : g_trig_chk
    a_trig_one_cycle : assert property (
      @(posedge i_pclk) disable iff (!i_prst_n)
      (trig_q[n] != '0) |=> (trig_q[n] == '0)
    );
  end

endmodule

`default_nettype wire

//--- cnt_channel.sv
`timescale 1ns/1ps
`default_nettype none

module cnt_channel (
  input  logic               i_pclk,
  input  logic               i_prst_n,
  input  cnt_pkg::cnt_cfg_t  i_cfg,
  input  cnt_pkg::cnt_trig_t i_trig,
  input  logic               i_cap_read,
  input  logic               i_din_a,
  output logic               o_dout_a,
  output logic               o_dout_a_oen,
  output cnt_pkg::cnt_stat_t o_stat
);

  logic                      run_q;
  logic [cnt_pkg::CNT_W-1:0] cnt_q;
  logic [cnt_pkg::CNT_W-1:0] cap_q;
  logic                      cap_full_q;
  logic                      dout_q;
  logic                      cmp_evt_q;
  logic                      cap_evt_q;
  logic                      din_s1;
  logic                      din_s2;
  logic                      din_d;
  logic                      counting;
  logic                      cmp_hit;
  logic                      edge_hit;
  logic                      cap_take;

  // increments only with run flag and enable both set
  assign counting = run_q & i_cfg.enable;
  // match wraps the counter, a clear in the same cycle suppresses it
  assign cmp_hit  = counting & ~i_trig.clear & (cnt_q == i_cfg.target);

  // run flag, stop beats start
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      run_q <= 1'b0;
    end else if (i_trig.stop) begin
      run_q <= 1'b0;
    end else if (i_trig.start) begin
      run_q <= 1'b1;
    end
  end

  // counter, clear has top priority
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      cnt_q <= '0;
    end else if (i_trig.clear) begin
      cnt_q <= '0;
    end else if (cmp_hit) begin
      cnt_q <= '0;
    end else if (counting) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // waveform toggles on every match
  // so each half period is target+1 cycles
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      dout_q    <= 1'b0;
      cmp_evt_q <= 1'b0;
    end else begin
      dout_q    <= dout_q ^ cmp_hit;
      cmp_evt_q <= cmp_hit;
    end
  end

  // two-flop sync, then one more stage for edge detect
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      din_s1 <= 1'b0;
      din_s2 <= 1'b0;
      din_d  <= 1'b0;
    end else begin
      din_s1 <= i_din_a;
      din_s2 <= din_s1;
      din_d  <= din_s2;
    end
  end

  // edge select, 0 rising and 1 falling
  assign edge_hit = i_cfg.capture_edge ? (din_d & ~din_s2) : (din_s2 & ~din_d);
  // one credit, a full slot only takes a new value with overwrite
  assign cap_take = i_cfg.enable & edge_hit & (~cap_full_q | i_cfg.overwrite);

  // credit state, a capture in the read cycle keeps the slot full
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      cap_full_q <= 1'b0;
      cap_evt_q  <= 1'b0;
    end else begin
      cap_evt_q <= cap_take;
      if (cap_take) begin
        cap_full_q <= 1'b1;
      end else if (i_cap_read) begin
        cap_full_q <= 1'b0;
      end
    end
  end

  // captured count
  always_ff @(posedge i_pclk) begin
    if (cap_take) begin
      cap_q <= cnt_q;
    end
  end

  assign o_dout_a     = dout_q;
  assign o_dout_a_oen = i_cfg.enable;

  assign o_stat.count    = cnt_q;
  assign o_stat.capture  = cap_q;
  assign o_stat.running  = run_q;
  assign o_stat.cap_full = cap_full_q;
  assign o_stat.cmp_evt  = cmp_evt_q;
  assign o_stat.cap_evt  = cap_evt_q;

  // a held capture is not lost while discard mode is on
  a_cap_hold : assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    (cap_full_q && !i_cfg.overwrite) |=> $stable(cap_q)
  );

endmodule

`default_nettype wire

//--- cnt_intr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cnt_intr_ctrl (
  input  logic                       i_pclk,
  input  logic                       i_prst_n,
  input  logic [cnt_pkg::INTR_W-1:0] i_evt,
  input  cnt_pkg::intr_wr_t          i_wr,
  output logic [cnt_pkg::INTR_W-1:0] o_sts,
  output logic [cnt_pkg::INTR_W-1:0] o_mask,
  output logic                       o_int
);

  logic [cnt_pkg::INTR_W-1:0] sts_q;
  logic [cnt_pkg::INTR_W-1:0] mask_q;
  logic [cnt_pkg::INTR_W-1:0] sts_clr;
  logic                       int_q;

  // w1c bits for this cycle
  assign sts_clr = i_wr.sts_clr_wr ? i_wr.data : '0;

  // sticky status where a new event beats the clear
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      sts_q <= '0;
    end else begin
      sts_q <= (sts_q & ~sts_clr) | i_evt;
    end
  end

  // mask with separate set and clear words
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      mask_q <= '0;
    end else if (i_wr.mask_set_wr) begin
      mask_q <= mask_q | i_wr.data;
    end else if (i_wr.mask_clr_wr) begin
      mask_q <= mask_q & ~i_wr.data;
    end
  end

  // level irq one cycle behind status
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      int_q <= 1'b0;
    end else begin
      int_q <= |(sts_q & mask_q);
    end
  end

  assign o_sts  = sts_q;
  assign o_mask = mask_q;
  assign o_int  = int_q;

  // a raised irq still has an enabled pending source
  // unless software cleared status or mask at the last edge
  a_int_cause : assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    o_int |-> (|(sts_q & mask_q)) || $past(i_wr.sts_clr_wr || i_wr.mask_clr_wr)
  );

endmodule

`default_nettype wire

//--- counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module counter_top (
  input  logic                        i_pclk,
  input  logic                        i_prst_n,
  input  logic [31:0]                 i_paddr,
  input  logic [31:0]                 i_pwdata,
  input  logic                        i_pwrite,
  input  logic                        i_psel,
  input  logic                        i_penable,
  output logic [31:0]                 o_prdata,
  input  logic [cnt_pkg::CNT_NUM-1:0] i_extern_din_a,
  output logic [cnt_pkg::CNT_NUM-1:0] o_extern_dout_a,
  output logic [cnt_pkg::CNT_NUM-1:0] o_extern_dout_a_oen,
  output logic                        o_int
);

  cnt_pkg::cnt_cfg_t          cfg [cnt_pkg::CNT_NUM];
  cnt_pkg::cnt_trig_t         trig [cnt_pkg::CNT_NUM];
  cnt_pkg::cnt_stat_t         stat [cnt_pkg::CNT_NUM];
  logic [cnt_pkg::CNT_NUM-1:0] cap_read;
  cnt_pkg::intr_wr_t          intr_wr;
  logic [cnt_pkg::INTR_W-1:0] intr_sts;
  logic [cnt_pkg::INTR_W-1:0] intr_mask;
  logic [cnt_pkg::INTR_W-1:0] intr_evt;

  // register block
  cnt_apb_regs u_regs (
    .i_pclk      (i_pclk),
    .i_prst_n    (i_prst_n),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .i_pwrite    (i_pwrite),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .o_prdata    (o_prdata),
    .o_cfg       (cfg),
    .o_trig      (trig),
    .o_cap_read  (cap_read),
    .i_stat      (stat),
    .o_intr_wr   (intr_wr),
    .i_intr_sts  (intr_sts),
    .i_intr_mask (intr_mask)
  );

  for (genvar n = 0; n < cnt_pkg::CNT_NUM; n++) begin : g_ch
    cnt_channel u_ch (
      .i_pclk       (i_pclk),
      .i_prst_n     (i_prst_n),
      .i_cfg        (cfg[n]),
      .i_trig       (trig[n]),
      .i_cap_read   (cap_read[n]),
      .i_din_a      (i_extern_din_a[n]),
      .o_dout_a     (o_extern_dout_a[n]),
      .o_dout_a_oen (o_extern_dout_a_oen[n]),
      .o_stat       (stat[n])
    );
    // compare on even bits, capture on odd
    assign intr_evt[2*n]   = stat[n].cmp_evt;
    assign intr_evt[2*n+1] = stat[n].cap_evt;
  end

  cnt_intr_ctrl u_intr (
    .i_pclk   (i_pclk),
    .i_prst_n (i_prst_n),
    .i_evt    (intr_evt),
    .i_wr     (intr_wr),
    .o_sts    (intr_sts),
    .o_mask   (intr_mask),
    .o_int    (o_int)
  );

endmodule

`default_nettype wire

//--- tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// zero-wait APB write, takes effect at the edge ending setup
task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
  @(posedge pclk);
  paddr   <= addr;
  pwdata  <= data;
  pwrite  <= 1'b1;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge pclk);
  penable <= 1'b1;
  @(posedge pclk);
  psel    <= 1'b0;
  penable <= 1'b0;
  pwrite  <= 1'b0;
endtask

// read data is latched at the setup edge, sampled at the end of access
task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
  @(posedge pclk);
  paddr   <= addr;
  pwrite  <= 1'b0;
  psel    <= 1'b1;
  penable <= 1'b0;
  @(posedge pclk);
  penable <= 1'b1;
  @(posedge pclk);
  data = prdata;
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
  logic [31:0] got;
  apb_read(addr, got);
  assert (got === exp) else
    stop_on_error($sformatf("%s: addr 0x%08h read 0x%08h, expected 0x%08h",
                            what, addr, got, exp));
endtask

task automatic wait_clocks(input int n);
  repeat (n) @(posedge pclk);
endtask

// poll status until one bit sets, bounded by a read count
task automatic wait_sts_bit(input int bit_idx, input int max_reads);
  logic [31:0] sts;
  int          reads;
  reads = 0;
  do begin
    apb_read(cnt_pkg::ADDR_INTR_STS, sts);
    reads++;
  end while (!sts[bit_idx] && reads < max_reads);
  assert (sts[bit_idx]) else
    stop_on_error($sformatf("status bit %0d never set within %0d reads", bit_idx, reads));
endtask

// o_int sampled at the clock edge
task automatic wait_int_level(input logic level, input int max_cycles);
  int cycles;
  cycles = 0;
  while (intr !== level && cycles < max_cycles) begin
    @(posedge pclk);
    cycles++;
  end
  assert (intr === level) else
    stop_on_error($sformatf("o_int did not go to %0b within %0d cycles", level, max_cycles));
endtask

// cycles until dout_a of one channel changes
task automatic wait_dout_toggle(input int ch, input int max_cycles, output int cycles);
  logic prev;
  prev   = dout_a[ch];
  cycles = 0;
  do begin
    @(posedge pclk);
    cycles++;
  end while (dout_a[ch] === prev && cycles < max_cycles);
  assert (dout_a[ch] !== prev) else
    stop_on_error($sformatf("dout_a[%0d] did not toggle within %0d cycles", ch, max_cycles));
endtask

`endif

//--- tb_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_counter_top;

  localparam int CLK_PERIOD = 10;
  // cycle budget per test
  localparam int BUDGET_RESET    = 20;
  localparam int BUDGET_READBACK = 300;
  localparam int BUDGET_TRIG     = 200;
  localparam int BUDGET_CMP      = 300;
  localparam int BUDGET_CAP      = 800;
  localparam int BUDGET_INTR     = 500;
  localparam int BUDGET_GLB      = 400;
  localparam int WDOG_CYCLES     = BUDGET_RESET + BUDGET_READBACK + BUDGET_TRIG +
                                   BUDGET_CMP + BUDGET_CAP + BUDGET_INTR + BUDGET_GLB;

  // CTRL words
  localparam logic [31:0] C_EN    = 32'h1 << cnt_pkg::CTRL_EN_BIT;
  localparam logic [31:0] C_EDGE  = 32'h1 << cnt_pkg::CTRL_EDGE_BIT;
  localparam logic [31:0] C_OVWR  = 32'h1 << cnt_pkg::CTRL_OVWR_BIT;
  localparam logic [31:0] C_START = 32'h1 << cnt_pkg::CTRL_START_BIT;
  localparam logic [31:0] C_STOP  = 32'h1 << cnt_pkg::CTRL_STOP_BIT;
  localparam logic [31:0] C_CLEAR = 32'h1 << cnt_pkg::CTRL_CLEAR_BIT;
  localparam logic [31:0] C_RUN   = 32'h1 << cnt_pkg::CTRL_RUN_BIT;
  localparam logic [31:0] C_FULL  = 32'h1 << cnt_pkg::CTRL_FULL_BIT;

  logic        pclk;
  logic        prst_n;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic        pwrite;
  logic        psel;
  logic        penable;
  logic [31:0] prdata;
  logic [3:0]  din_a;
  logic [3:0]  dout_a;
  logic [3:0]  dout_oen;
  logic        intr;
  integer      seed;

  counter_top dut (
    .i_pclk              (pclk),
    .i_prst_n            (prst_n),
    .i_paddr             (paddr),
    .i_pwdata            (pwdata),
    .i_pwrite            (pwrite),
    .i_psel              (psel),
    .i_penable           (penable),
    .o_prdata            (prdata),
    .i_extern_din_a      (din_a),
    .o_extern_dout_a     (dout_a),
    .o_extern_dout_a_oen (dout_oen),
    .o_int               (intr)
  );

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  task automatic stop_on_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // byte address of a register in channel ch
  function automatic logic [31:0] ch_addr(input int ch, input logic [3:0] ofs);
    return cnt_pkg::CH_BASE + ch * cnt_pkg::CH_STRIDE + {28'h0, ofs};
  endfunction

  `include "tb_apb_tasks.svh"

  // low then high, a rising edge on one din_a pin
  task automatic pulse_din(input int ch);
    @(posedge pclk);
    din_a[ch] <= 1'b0;
    wait_clocks(4);
    din_a[ch] <= 1'b1;
  endtask

  // capture status bit of ch must set after an edge
  task automatic capture_once(input int ch);
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'h1 << (2 * ch + 1));
    pulse_din(ch);
    wait_sts_bit(2 * ch + 1, 10);
  endtask

  // run ch for a while, leave it stopped and enabled
  task automatic run_for(input int ch, input int n, output logic [31:0] cnt);
    apb_write(ch_addr(ch, cnt_pkg::OFS_CTRL), C_EN | C_START);
    wait_clocks(n);
    apb_write(ch_addr(ch, cnt_pkg::OFS_CTRL), C_EN | C_STOP);
    apb_read(ch_addr(ch, cnt_pkg::OFS_COUNT), cnt);
  endtask

  task automatic test_reset_readback();
    logic [31:0] tgt;
    logic [31:0] rnd;
    logic [31:0] ctl;
    assert (intr === 1'b0 && dout_a === 4'h0 && dout_oen === 4'h0) else
      stop_on_error("outputs not idle after reset");
    read_check(cnt_pkg::ADDR_INTR_STS, 32'h0, "status after reset");
    read_check(cnt_pkg::ADDR_MASK_SET, 32'h0, "mask after reset");
    for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
      read_check(ch_addr(n, cnt_pkg::OFS_CTRL), 32'h0, "ctrl after reset");
      read_check(ch_addr(n, cnt_pkg::OFS_COUNT), 32'h0, "count after reset");
      tgt = $random(seed);
      rnd = $random(seed);
      ctl = (rnd[0] ? C_EN : 32'h0) | (rnd[1] ? C_EDGE : 32'h0) | (rnd[2] ? C_OVWR : 32'h0);
      apb_write(ch_addr(n, cnt_pkg::OFS_TARGET), tgt);
      // stop and clear ride along, must read back as 0
      apb_write(ch_addr(n, cnt_pkg::OFS_CTRL), ctl | C_STOP | C_CLEAR);
      read_check(ch_addr(n, cnt_pkg::OFS_TARGET), tgt, "target read-back");
      read_check(ch_addr(n, cnt_pkg::OFS_CTRL), ctl, "ctrl read-back");
      assert (dout_oen[n] === rnd[0]) else
        stop_on_error($sformatf("oen[%0d] is %0b, enable is %0b", n, dout_oen[n], rnd[0]));
      apb_write(ch_addr(n, cnt_pkg::OFS_CTRL), 32'h0);
    end
  endtask

  task automatic test_single_triggers();
    logic [31:0] c1;
    logic [31:0] c2;
    apb_write(ch_addr(0, cnt_pkg::OFS_TARGET), 32'hFFFF_FFFF);
    apb_write(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN | C_START);
    apb_read(ch_addr(0, cnt_pkg::OFS_COUNT), c1);
    apb_read(ch_addr(0, cnt_pkg::OFS_COUNT), c2);
    assert (c2 > c1) else
      stop_on_error($sformatf("count not rising after start: %0d then %0d", c1, c2));
    read_check(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN | C_RUN, "running flag after start");
    apb_write(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN | C_STOP);
    apb_read(ch_addr(0, cnt_pkg::OFS_COUNT), c1);
    apb_read(ch_addr(0, cnt_pkg::OFS_COUNT), c2);
    assert (c1 == c2 && c1 != 0) else
      stop_on_error($sformatf("count moved after stop: %0d then %0d", c1, c2));
    read_check(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN, "running flag after stop");
    apb_write(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN | C_CLEAR);
    read_check(ch_addr(0, cnt_pkg::OFS_COUNT), 32'h0, "count after clear");
    apb_write(ch_addr(0, cnt_pkg::OFS_CTRL), 32'h0);
  endtask

  task automatic test_compare();
    logic [31:0] rnd;
    logic [31:0] sts;
    int          t;
    int          cyc;
    rnd = $random(seed);
    t   = 3 + rnd[2:0];
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'hFF);
    apb_write(ch_addr(1, cnt_pkg::OFS_TARGET), t);
    apb_write(ch_addr(1, cnt_pkg::OFS_CTRL), C_EN | C_CLEAR | C_START);
    // first toggle only aligns to the waveform
    wait_dout_toggle(1, 4 * (t + 1), cyc);
    for (int k = 0; k < 2; k++) begin
      wait_dout_toggle(1, 4 * (t + 1), cyc);
      assert (cyc == t + 1) else
        stop_on_error($sformatf("dout_a[1] half period %0d, expected %0d", cyc, t + 1));
    end
    apb_read(cnt_pkg::ADDR_INTR_STS, sts);
    assert (sts[2]) else
      stop_on_error($sformatf("compare status bit 2 clear, status 0x%02h", sts));
    apb_write(ch_addr(1, cnt_pkg::OFS_CTRL), C_EN | C_STOP | C_CLEAR);
    apb_write(ch_addr(1, cnt_pkg::OFS_CTRL), 32'h0);
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'hFF);
  endtask

  task automatic test_capture_credit();
    logic [31:0] k;
    logic [31:0] sts;
    logic [31:0] a_ctrl;
    logic [31:0] a_cap;
    a_ctrl = ch_addr(2, cnt_pkg::OFS_CTRL);
    a_cap  = ch_addr(2, cnt_pkg::OFS_CAPTURE);
    apb_write(ch_addr(2, cnt_pkg::OFS_TARGET), 32'hFFFF_FFFF);
    run_for(2, 12, k);
    capture_once(2);
    read_check(a_ctrl, C_EN | C_FULL, "full after capture");
    read_check(a_cap, k, "captured count");
    read_check(a_ctrl, C_EN, "full after capture read");
    // refill, then clear with overwrite off
    capture_once(2);
    apb_write(a_ctrl, C_EN | C_CLEAR);
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'h20);
    pulse_din(2);
    wait_clocks(8);
    apb_read(cnt_pkg::ADDR_INTR_STS, sts);
    assert (!sts[5]) else
      stop_on_error("capture event raised for an edge on a full slot");
    read_check(a_ctrl, C_EN | C_FULL, "full after dropped edge");
    read_check(a_cap, k, "capture after dropped edge");
    // nonzero value in the slot, then overwrite it with 0
    run_for(2, 6, k);
    capture_once(2);
    apb_write(a_ctrl, C_EN | C_OVWR | C_CLEAR);
    capture_once(2);
    read_check(a_cap, 32'h0, "capture after overwrite");
    read_check(a_ctrl, C_EN | C_OVWR, "full after overwrite read");
    apb_write(a_ctrl, 32'h0);
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'hFF);
  endtask

  task automatic test_interrupts();
    logic [31:0] rd;
    apb_write(ch_addr(3, cnt_pkg::OFS_CTRL), C_EN);
    capture_once(3);
    wait_clocks(5);
    assert (intr === 1'b0) else
      stop_on_error("o_int high while the mask is clear");
    apb_write(cnt_pkg::ADDR_MASK_SET, 32'h80);
    read_check(cnt_pkg::ADDR_MASK_SET, 32'h80, "mask read-back");
    wait_int_level(1'b1, 20);
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'h80);
    wait_int_level(1'b0, 20);
    // credit back, then a second capture event
    apb_read(ch_addr(3, cnt_pkg::OFS_CAPTURE), rd);
    capture_once(3);
    wait_int_level(1'b1, 20);
    apb_write(cnt_pkg::ADDR_MASK_CLR, 32'h80);
    wait_int_level(1'b0, 20);
    read_check(cnt_pkg::ADDR_MASK_SET, 32'h0, "mask after mask clear");
    apb_write(cnt_pkg::ADDR_INTR_STS, 32'hFF);
    apb_write(ch_addr(3, cnt_pkg::OFS_CTRL), 32'h0);
  endtask

  task automatic test_global_triggers();
    logic [31:0] k1;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] ctl;
    for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
      apb_write(ch_addr(n, cnt_pkg::OFS_TARGET), 32'hFFFF_FFFF);
      apb_write(ch_addr(n, cnt_pkg::OFS_CTRL), C_STOP | C_CLEAR);
    end
    // channel 1 keeps a count but is disabled
    run_for(1, 6, k1);
    apb_write(ch_addr(1, cnt_pkg::OFS_CTRL), 32'h0);
    apb_write(ch_addr(0, cnt_pkg::OFS_CTRL), C_EN);
    apb_write(ch_addr(2, cnt_pkg::OFS_CTRL), C_EN);
    apb_write(cnt_pkg::ADDR_GLB_TRIG, 32'h1 << cnt_pkg::TRIG_START_BIT);
    for (int n = 0; n < cnt_pkg::CNT_NUM; n++) begin
      apb_read(ch_addr(n, cnt_pkg::OFS_COUNT), c1);
      apb_read(ch_addr(n, cnt_pkg::OFS_COUNT), c2);
      apb_read(ch_addr(n, cnt_pkg::OFS_CTRL), ctl);
      if (n % 2 == 0) begin
        assert (c2 > c1 && ctl[cnt_pkg::CTRL_RUN_BIT]) else
          stop_on_error($sformatf("enabled ch%0d not running: %0d then %0d", n, c1, c2));
      end else begin
        assert (c1 == c2 && c1 == (n == 1 ? k1 : 32'h0) && !ctl[cnt_pkg::CTRL_RUN_BIT]) else
          stop_on_error($sformatf("disabled ch%0d moved: %0d then %0d", n, c1, c2));
      end
    end
    apb_write(cnt_pkg::ADDR_GLB_TRIG,
              (32'h1 << cnt_pkg::TRIG_STOP_BIT) | (32'h1 << cnt_pkg::TRIG_CLEAR_BIT));
    read_check(ch_addr(0, cnt_pkg::OFS_COUNT), 32'h0, "ch0 after global clear");
    read_check(ch_addr(1, cnt_pkg::OFS_COUNT), k1, "ch1 after global clear");
    read_check(ch_addr(2, cnt_pkg::OFS_COUNT), 32'h0, "ch2 after global clear");
    read_check(ch_addr(3, cnt_pkg::OFS_COUNT), 32'h0, "ch3 after global clear");
  endtask

  // bounds the whole run
  initial begin
    repeat (WDOG_CYCLES) @(posedge pclk);
    $display("timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
    $display(">>> FAIL");
    $fatal(1);
  end

  initial begin
    seed    = 52;
    pclk    = 1'b0;
    prst_n  = 1'b0;
    paddr   = 32'h0;
    pwdata  = 32'h0;
    pwrite  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    din_a   = 4'h0;
    repeat (8) @(posedge pclk);
    prst_n <= 1'b1;
    wait_clocks(2);
    test_reset_readback();
    test_single_triggers();
    test_compare();
    test_capture_credit();
    test_interrupts();
    test_global_triggers();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
cnt_pkg.sv
cnt_apb_regs.sv
cnt_channel.sv
cnt_intr_ctrl.sv
counter_top.sv
tb_counter_top.sv
